//--- logic/predict_pkg.sv
// Next-fetch predictor shared definitions
// Address and table widths, branch kind codes and stored entry records
`default_nettype none

package predict_pkg;

    localparam int addr_width  = 32;
    localparam int index_bits  = 5;
    localparam int tag_bits    = addr_width - 8;
    localparam int hist_width  = 10;
    localparam int stack_depth = 8;
    localparam int stack_bits  = $clog2(stack_depth);

    // Branch kinds, low two bits of info
    localparam logic [1:0] kind_cond  = 2'b00;
    localparam logic [1:0] kind_guess = 2'b01;
    localparam logic [1:0] kind_jump  = 2'b10;
    localparam logic [1:0] kind_ret   = 2'b11;

    // Weakly not taken
    localparam logic [1:0] counter_init = 2'b01;

    typedef struct packed {
        logic [tag_bits-1:0]   tag;
        logic [1:0]            kind;
        logic [addr_width-3:0] target;
    } target_entry_t;

    typedef struct packed {
        logic [1:0] guess1;
        logic [1:0] guess2;
    } guess_entry_t;

endpackage

`default_nettype wire

//--- logic/lut_memory.sv
// Small lookup memory
// Combinational read port and one synchronous write port, entry type set by parameter
`timescale 1ns/1ps
`default_nettype none

module lut_memory #(
    parameter type entry_t    = logic [7:0],
    parameter int  depth_bits = 5
) (
    input  wire                    clk,
    input  wire                    wr_en,
    input  wire [depth_bits-1:0]   wr_addr,
    input  wire entry_t            wr_data,
    input  wire [depth_bits-1:0]   rd_addr,
    output entry_t                 rd_data
);

    entry_t mem [2**depth_bits];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

//--- logic/target_buffer.sv
// Branch target buffer
// Per packet and slot, records whether a branch lives there, its kind and target.
// Lookup by pc_now is combinational, execute results install entries.
`timescale 1ns/1ps
`default_nettype none

module target_buffer (
    input  wire                               clk,
    input  wire                               rstn,
    input  wire [predict_pkg::addr_width-1:0] pc_now,
    input  wire                               ex_vld,
    input  wire [predict_pkg::addr_width-1:0] ex_pc,
    input  wire [1:0]                         ex_kind,
    input  wire [predict_pkg::addr_width-1:0] ex_target,
    output logic                              exist1,
    output logic                              exist2,
    output logic [predict_pkg::addr_width-1:0] info1,
    output logic [predict_pkg::addr_width-1:0] info2
);
    import predict_pkg::*;

    logic [index_bits-1:0] rd_index;
    logic [index_bits-1:0] wr_index;
    logic [1:0]            wr_slot;
    target_entry_t         wr_entry;

    assign rd_index = pc_now[index_bits+2:3];
    assign wr_index = ex_pc[index_bits+2:3];
    // ex_pc[2] picks the slot
    assign wr_slot  = {ex_vld & ex_pc[2], ex_vld & ~ex_pc[2]};
    assign wr_entry = '{tag: ex_pc[addr_width-1:8], kind: ex_kind,
                        target: ex_target[addr_width-1:2]};

    for (genvar s = 0; s < 2; s++) begin : g_slot
        logic [2**index_bits-1:0] valid;
        target_entry_t            rd_entry;
        logic                     hit;

        lut_memory #(.entry_t(target_entry_t), .depth_bits(index_bits)) entries (
            .clk     (clk),
            .wr_en   (wr_slot[s]),
            .wr_addr (wr_index),
            .wr_data (wr_entry),
            .rd_addr (rd_index),
            .rd_data (rd_entry)
        );

        always_ff @(posedge clk) begin
            if (!rstn) begin
                valid <= '0;
            end else if (wr_slot[s]) begin
                valid[wr_index] <= 1'b1;
            end
        end

        assign hit = valid[rd_index] && (rd_entry.tag == pc_now[addr_width-1:8]);
    end

    // Info is target word then kind
    assign exist1 = g_slot[0].hit;
    assign exist2 = g_slot[1].hit;
    assign info1  = {g_slot[0].rd_entry.target, g_slot[0].rd_entry.kind};
    assign info2  = {g_slot[1].rd_entry.target, g_slot[1].rd_entry.kind};

endmodule

`default_nettype wire

//--- logic/history_table.sv
// Local history table
// Per packet and slot, a 2-bit local history and four 2-bit pattern counters.
// Conditional branches resolved by execute train the selected counter.
`timescale 1ns/1ps
`default_nettype none

module history_table (
    input  wire                               clk,
    input  wire                               rstn,
    input  wire [predict_pkg::addr_width-1:0] pc_now,
    input  wire                               ex_vld,
    input  wire [predict_pkg::addr_width-1:0] ex_pc,
    input  wire [1:0]                         ex_kind,
    input  wire                               ex_taken,
    output logic                              past_vld1,
    output logic                              past_vld2,
    output logic [predict_pkg::hist_width-1:0] past1,
    output logic [predict_pkg::hist_width-1:0] past2
);
    import predict_pkg::*;

    logic [index_bits-1:0] rd_index;
    logic [index_bits-1:0] ex_index;
    logic                  ex_cond;

    assign rd_index = pc_now[index_bits+2:3];
    assign ex_index = ex_pc[index_bits+2:3];
    assign ex_cond  = ex_vld && (ex_kind == kind_cond || ex_kind == kind_guess);

    for (genvar s = 0; s < 2; s++) begin : g_slot
        logic [2**index_bits-1:0] valid;
        logic                     train;
        logic [index_bits-1:0]    addr;
        logic [hist_width-1:0]    rd_entry;
        logic [hist_width-1:0]    old_entry;
        logic [hist_width-1:0]    new_entry;
        logic [1:0]               hist;
        logic [1:0]               cnt;
        logic [1:0]               cnt_next;

        assign train = ex_cond && (ex_pc[2] == s[0]);
        // Training borrows this slot's read port for the cycle
        assign addr  = train ? ex_index : rd_index;

        lut_memory #(.entry_t(logic [hist_width-1:0]), .depth_bits(index_bits)) entries (
            .clk     (clk),
            .wr_en   (train),
            .wr_addr (ex_index),
            .wr_data (new_entry),
            .rd_addr (addr),
            .rd_data (rd_entry)
        );

        always_comb begin
            old_entry = valid[ex_index] ? rd_entry : {2'b00, {4{counter_init}}};
            hist      = old_entry[hist_width-1 -: 2];
            cnt       = old_entry[{hist, 1'b0} +: 2];
            // Saturating counter
            if (ex_taken) begin
                cnt_next = (cnt == 2'b11) ? cnt : cnt + 2'd1;
            end else begin
                cnt_next = (cnt == 2'b00) ? cnt : cnt - 2'd1;
            end
            new_entry = old_entry;
            new_entry[{hist, 1'b0} +: 2]  = cnt_next;
            new_entry[hist_width-1 -: 2] = {hist[0], ex_taken};
        end

        always_ff @(posedge clk) begin
            if (!rstn) begin
                valid <= '0;
            end else if (train) begin
                valid[ex_index] <= 1'b1;
            end
        end
    end

    assign past_vld1 = g_slot[0].valid[rd_index];
    assign past_vld2 = g_slot[1].valid[rd_index];
    assign past1     = g_slot[0].rd_entry;
    assign past2     = g_slot[1].rd_entry;

endmodule

`default_nettype wire

//--- logic/return_stack.sv
// Return address stack
// Circular stack of call return addresses. The first speculative pop saves
// the pointer, and a clear rolls back to it.
`timescale 1ns/1ps
`default_nettype none

module return_stack (
    input  wire                               clk,
    input  wire                               rstn,
    input  wire                               push,
    input  wire [predict_pkg::addr_width-1:0] addr,
    input  wire                               pop,
    input  wire                               spec,
    input  wire                               clear,
    output logic                              empty,
    output logic [predict_pkg::addr_width-1:0] top
);
    import predict_pkg::*;

    logic [addr_width-1:0] stack_mem [stack_depth];
    logic [stack_bits-1:0] sp;
    logic [stack_bits-1:0] sp_top;
    logic [stack_bits:0]   count;
    logic [stack_bits-1:0] ck_sp;
    logic [stack_bits:0]   ck_count;
    logic                  ck_held;
    logic                  do_pop;

    // sp is the next free slot
    assign sp_top = sp - 1'b1;
    assign empty  = (count == '0);
    assign top    = stack_mem[sp_top];
    assign do_pop = pop & ~empty;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            sp       <= '0;
            count    <= '0;
            ck_sp    <= '0;
            ck_count <= '0;
            ck_held  <= 1'b0;
        end else if (clear) begin
            if (ck_held) begin
                sp    <= ck_sp;
                count <= ck_count;
            end
            ck_held <= 1'b0;
        end else begin
            if (push && !do_pop) begin
                sp <= sp + 1'b1;
                // Full stack wraps over the oldest entry
                if (count != stack_depth) begin
                    count <= count + 1'b1;
                end
            end else if (do_pop && !push) begin
                sp    <= sp_top;
                count <= count - 1'b1;
            end
            if (do_pop && spec && !ck_held) begin
                ck_held  <= 1'b1;
                ck_sp    <= sp;
                ck_count <= count;
            end
        end
    end

    // Push with pop replaces the top
    always_ff @(posedge clk) begin
        if (push && !clear) begin
            stack_mem[do_pop ? sp_top : sp] <= addr;
        end
    end

endmodule

`default_nettype wire

//--- logic/predict_unit.sv
// Next-fetch predict unit
// Combines target buffer, history and return stack lookups into pc_new,
// branch and reason in the same cycle. Keeps a guess log for packets
// predicted again before execute resolves them.
`timescale 1ns/1ps
`default_nettype none

module predict_unit (
    input  wire                               clk,
    input  wire                               rstn,
    input  wire                               en,
    input  wire [predict_pkg::addr_width-1:0] pc_now,
    input  wire                               exist1,
    input  wire                               exist2,
    input  wire [predict_pkg::addr_width-1:0] info1,
    input  wire [predict_pkg::addr_width-1:0] info2,
    input  wire                               past_vld1,
    input  wire                               past_vld2,
    input  wire [predict_pkg::hist_width-1:0] past1,
    input  wire [predict_pkg::hist_width-1:0] past2,
    input  wire                               ex_vld,
    input  wire                               ex_wrong,
    input  wire                               empty,
    input  wire [predict_pkg::addr_width-1:0] top,
    output logic                              pop,
    output logic                              spec,
    output logic [predict_pkg::addr_width-1:0] pc_new,
    output logic                              branch,
    output logic                              reason
);
    import predict_pkg::*;

    logic [index_bits-1:0]    index;
    guess_entry_t             log_rd;
    guess_entry_t             log_wr;
    logic [2**index_bits-1:0] flag1;
    logic [2**index_bits-1:0] flag2;
    logic                     in_guess1;
    logic                     in_guess2;
    logic [1:0]               hist1;
    logic [1:0]               hist2;
    logic                     take1;
    logic                     take2;
    logic                     new1;
    logic                     new2;
    logic [addr_width-1:0]    sel_info;
    logic [addr_width-1:0]    pc_norm;
    logic                     is_ret;

    function automatic logic slot_taken(
        input logic                  exist,
        input logic                  past_vld,
        input logic                  cnt_bit,
        input logic [addr_width-1:0] info,
        input logic [addr_width-3:0] pc_word
    );
        if (!exist) begin
            return 1'b0;
        end
        if (past_vld) begin
            return cnt_bit;
        end
        // Jumps and returns, then backward is taken
        if (info[1]) begin
            return 1'b1;
        end
        return info[addr_width-1:2] < pc_word;
    endfunction

    assign index = pc_now[index_bits+2:3];

    ////////////////////////////////////////////////////////////////////////////
    // Guess log
    ////////////////////////////////////////////////////////////////////////////

    lut_memory #(.entry_t(guess_entry_t), .depth_bits(index_bits)) guess_log (
        .clk     (clk),
        .wr_en   (en),
        .wr_addr (index),
        .wr_data (log_wr),
        .rd_addr (index),
        .rd_data (log_rd)
    );

    assign in_guess1 = flag1[index];
    assign in_guess2 = flag2[index];

    // Logged history stands in while a guess is outstanding
    assign hist1 = in_guess1 ? log_rd.guess1 : past1[hist_width-1 -: 2];
    assign hist2 = in_guess2 ? log_rd.guess2 : past2[hist_width-1 -: 2];

    assign take1 = ~pc_now[2] &
        slot_taken(exist1, past_vld1, past1[{hist1, 1'b1}], info1, pc_now[addr_width-1:2]);
    assign take2 =
        slot_taken(exist2, past_vld2, past2[{hist2, 1'b1}], info2, pc_now[addr_width-1:2]);

    // Slot 2 only guesses when slot 1 does not leave the packet
    assign new1 = ~pc_now[2] & exist1 & past_vld1 & (info1[1:0] == kind_guess);
    assign new2 = ~take1 & exist2 & past_vld2 & (info2[1:0] == kind_guess);

    assign log_wr.guess1 = new1 ? {hist1[0], take1} : log_rd.guess1;
    assign log_wr.guess2 = new2 ? {hist2[0], take2} : log_rd.guess2;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            flag1 <= '0;
            flag2 <= '0;
        end else if (ex_vld && ex_wrong) begin
            flag1 <= '0;
            flag2 <= '0;
        end else if (en) begin
            flag1[index] <= in_guess1 | new1;
            flag2[index] <= in_guess2 | new2;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Next pc
    ////////////////////////////////////////////////////////////////////////////

    assign branch   = take1 | take2;
    assign reason   = ~take1 & take2;
    assign sel_info = reason ? info2 : info1;
    assign is_ret   = branch && (sel_info[1:0] == kind_ret);
    assign pc_norm  = {pc_now[addr_width-1:3], 3'b000} + addr_width'(8);

    assign pop  = en & is_ret & ~empty;
    // Pops are speculative while any guess is unresolved
    assign spec = (|flag1) | (|flag2) | new1 | new2;

    always_comb begin
        if (is_ret) begin
            pc_new = empty ? pc_norm : top;
        end else if (branch) begin
            pc_new = {sel_info[addr_width-1:2], 2'b00};
        end else begin
            pc_new = pc_norm;
        end
    end

endmodule

`default_nettype wire

//--- logic/fetch_predictor.sv
// Dual-issue fetch next-pc predictor, top level
// Target buffer, history table, return stack and predict unit
`timescale 1ns/1ps
`default_nettype none

module fetch_predictor (
    input  wire                               clk,
    input  wire                               rstn,
    input  wire                               fetch_en,
    input  wire [predict_pkg::addr_width-1:0] pc_now,
    input  wire                               call_push,
    input  wire [predict_pkg::addr_width-1:0] call_addr,
    input  wire                               ex_vld,
    input  wire                               ex_wrong,
    input  wire [predict_pkg::addr_width-1:0] ex_pc,
    input  wire                               ex_taken,
    input  wire [1:0]                         ex_kind,
    input  wire [predict_pkg::addr_width-1:0] ex_target,
    output logic [predict_pkg::addr_width-1:0] pc_new,
    output logic                              branch,
    output logic                              reason
);
    import predict_pkg::*;

    logic                  exist1;
    logic                  exist2;
    logic [addr_width-1:0] info1;
    logic [addr_width-1:0] info2;
    logic                  past_vld1;
    logic                  past_vld2;
    logic [hist_width-1:0] past1;
    logic [hist_width-1:0] past2;
    logic                  pop;
    logic                  spec;
    logic                  empty;
    logic [addr_width-1:0] top;

    target_buffer target_buffer_inst (
        .clk (clk), .rstn (rstn), .pc_now (pc_now),
        .ex_vld (ex_vld), .ex_pc (ex_pc), .ex_kind (ex_kind), .ex_target (ex_target),
        .exist1 (exist1), .exist2 (exist2), .info1 (info1), .info2 (info2)
    );

    history_table history_table_inst (
        .clk (clk), .rstn (rstn), .pc_now (pc_now),
        .ex_vld (ex_vld), .ex_pc (ex_pc), .ex_kind (ex_kind), .ex_taken (ex_taken),
        .past_vld1 (past_vld1), .past_vld2 (past_vld2), .past1 (past1), .past2 (past2)
    );

    // Misprediction rolls the stack back
    return_stack return_stack_inst (
        .clk (clk), .rstn (rstn), .push (call_push), .addr (call_addr),
        .pop (pop), .spec (spec), .clear (ex_vld & ex_wrong),
        .empty (empty), .top (top)
    );

    predict_unit predict_unit_inst (
        .clk (clk), .rstn (rstn), .en (fetch_en), .pc_now (pc_now),
        .exist1 (exist1), .exist2 (exist2), .info1 (info1), .info2 (info2),
        .past_vld1 (past_vld1), .past_vld2 (past_vld2), .past1 (past1), .past2 (past2),
        .ex_vld (ex_vld), .ex_wrong (ex_wrong), .empty (empty), .top (top),
        .pop (pop), .spec (spec), .pc_new (pc_new), .branch (branch), .reason (reason)
    );

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
// Testbench clock source
// Free running clock, 20 ns period by default
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int period = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- verif/fetch_predictor_tb.sv
// Testbench for the next-fetch predictor
// Directed tests of idle prediction, slot priority, the static rule,
// counter training and the return stack, checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module fetch_predictor_tb;
    import predict_pkg::*;

    logic        clk;
    logic        rstn;
    logic        fetch_en;
    logic [31:0] pc_now;
    logic        call_push;
    logic [31:0] call_addr;
    logic        ex_vld;
    logic        ex_wrong;
    logic [31:0] ex_pc;
    logic        ex_taken;
    logic [1:0]  ex_kind;
    logic [31:0] ex_target;
    logic [31:0] pc_new;
    logic        branch;
    logic        reason;
    integer      seed;

    // Reference model arrays indexed by {packet index, slot}
    logic [63:0] tgt_valid;
    logic [23:0] tgt_tag [64];
    logic [1:0]  tgt_kind [64];
    logic [31:0] tgt_addr [64];
    logic [63:0] hist_valid;
    logic [9:0]  hist_entry [64];

    tb_clock #(.period(20)) clock_inst (.clk(clk));

    fetch_predictor fetch_predictor_inst (
        .clk (clk), .rstn (rstn), .fetch_en (fetch_en), .pc_now (pc_now),
        .call_push (call_push), .call_addr (call_addr),
        .ex_vld (ex_vld), .ex_wrong (ex_wrong), .ex_pc (ex_pc), .ex_taken (ex_taken),
        .ex_kind (ex_kind), .ex_target (ex_target),
        .pc_new (pc_new), .branch (branch), .reason (reason)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic wait_reset_done();
        int cycles;
        cycles = 0;
        while (branch !== 1'b0 || pc_new !== 32'd8) begin
            if (cycles == 20) begin
                $display("predictor did not come out of reset idle within 20 cycles");
                $display("*** TEST FAILED ***");
                $fatal(1, "reset timeout");
            end
            next_cycle();
            cycles++;
        end
    endtask

    // Counter and history update of a resolved conditional branch
    task automatic train_model(input logic [31:0] pc, input logic [1:0] kind,
                               input logic taken, input logic [31:0] target);
        logic [5:0] key;
        logic [9:0] entry;
        logic [1:0] h;
        logic [1:0] cnt;
        key = {pc[7:3], pc[2]};
        tgt_valid[key] = 1'b1;
        tgt_tag[key]   = pc[31:8];
        tgt_kind[key]  = kind;
        tgt_addr[key]  = {target[31:2], 2'b00};
        if (kind == kind_cond || kind == kind_guess) begin
            entry = hist_valid[key] ? hist_entry[key] : {2'b00, {4{counter_init}}};
            h     = entry[9:8];
            cnt   = entry[2*h +: 2];
            if (taken && cnt != 2'b11) begin
                cnt = cnt + 2'd1;
            end else if (!taken && cnt != 2'b00) begin
                cnt = cnt - 2'd1;
            end
            entry[2*h +: 2]  = cnt;
            entry[9:8]       = {h[0], taken};
            hist_entry[key]  = entry;
            hist_valid[key]  = 1'b1;
        end
    endtask

    task automatic predict_model(input logic [31:0] pc, output logic br,
                                 output logic rs, output logic [31:0] nxt);
        logic [5:0] key;
        logic [1:0] t;
        logic [1:0] h;
        t = 2'b00;
        for (int s = 0; s < 2; s++) begin
            key = {pc[7:3], s[0]};
            if (tgt_valid[key] && tgt_tag[key] == pc[31:8] && (s == 1 || !pc[2])) begin
                if (hist_valid[key]) begin
                    h    = hist_entry[key][9:8];
                    t[s] = hist_entry[key][2*h+1];
                end else if (tgt_kind[key][1]) begin
                    t[s] = 1'b1;
                end else begin
                    t[s] = tgt_addr[key][31:2] < pc[31:2];
                end
            end
        end
        br  = t[0] | t[1];
        rs  = !t[0] && t[1];
        key = {pc[7:3], rs};
        nxt = br ? tgt_addr[key] : {pc[31:3], 3'b000} + 32'd8;
    endtask

    task automatic execute(input logic [31:0] pc, input logic [1:0] kind, input logic taken,
                           input logic [31:0] target, input logic wrong);
        next_cycle();
        fetch_en  = 1'b0;
        ex_vld    = 1'b1;
        ex_wrong  = wrong;
        ex_pc     = pc;
        ex_kind   = kind;
        ex_taken  = taken;
        ex_target = target;
        next_cycle();
        ex_vld   = 1'b0;
        ex_wrong = 1'b0;
        train_model(pc, kind, taken, target);
    endtask

    task automatic check_pc(input logic [31:0] pc, input logic en);
        logic        exp_br;
        logic        exp_rs;
        logic [31:0] exp_pc;
        next_cycle();
        pc_now   = pc;
        fetch_en = en;
        #5;
        predict_model(pc, exp_br, exp_rs, exp_pc);
        compare(32'(branch), 32'(exp_br), "branch");
        compare(32'(reason), 32'(exp_rs), "reason");
        compare(pc_new, exp_pc, "pc_new");
    endtask

    task automatic push_call(input logic [31:0] addr);
        next_cycle();
        fetch_en  = 1'b0;
        call_push = 1'b1;
        call_addr = addr;
        next_cycle();
        call_push = 1'b0;
    endtask

    task automatic ret_check(input logic [31:0] pc, input logic en, input logic [31:0] exp);
        next_cycle();
        pc_now   = pc;
        fetch_en = en;
        #5;
        compare(32'(branch), 32'd1, "return branch");
        compare(32'(reason), 32'd0, "return reason");
        compare(pc_new, exp, "return pc_new");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic idle_predictions();
        logic [31:0] pc;
        for (int i = 0; i < 8; i++) begin
            pc      = $random(seed);
            pc[2:0] = 3'b000;
            next_cycle();
            pc_now = pc;
            #5;
            compare(32'(branch), 32'd0, "idle branch");
            compare(pc_new, pc + 32'd8, "idle pc_new");
            next_cycle();
            pc_now = pc | 32'd4;
            #5;
            compare(pc_new, pc + 32'd8, "idle pc_new from slot 2");
        end
    endtask

    task automatic slot_priority();
        execute(32'h0000_1040, kind_jump, 1'b1, 32'h0000_2000, 1'b0);
        // Three taken outcomes leave slot 2 on a taken counter
        for (int i = 0; i < 3; i++) begin
            execute(32'h0000_1044, kind_cond, 1'b1, 32'h0000_1000, 1'b0);
        end
        check_pc(32'h0000_1040, 1'b0);
        check_pc(32'h0000_1044, 1'b0);
    endtask

    task automatic static_direction();
        execute(32'h0000_1150, kind_cond, 1'b1, 32'h0000_1000, 1'b0);
        check_pc(32'h0000_1150, 1'b0);
        execute(32'h0000_1264, kind_cond, 1'b0, 32'h0000_2000, 1'b0);
        check_pc(32'h0000_1260, 1'b0);
        check_pc(32'h0000_1264, 1'b0);
        // Jump writes leave the trained history alone
        execute(32'h0000_1150, kind_jump, 1'b1, 32'h0000_1400, 1'b0);
        execute(32'h0000_1150, kind_jump, 1'b1, 32'h0000_1400, 1'b0);
        check_pc(32'h0000_1150, 1'b0);
    endtask

    task automatic counter_training();
        logic [15:0] outcomes;
        outcomes = 16'b1011_0011_1110_0101;
        for (int i = 0; i < 16; i++) begin
            execute(32'h0000_1378, kind_cond, outcomes[i], 32'h0000_1300, 1'b0);
            check_pc(32'h0000_1378, 1'b0);
        end
    endtask

    task automatic return_addresses();
        execute(32'h0000_3080, kind_ret, 1'b1, 32'h0, 1'b0);
        push_call(32'h0000_5004);
        push_call(32'h0000_6008);
        ret_check(32'h0000_3080, 1'b0, 32'h0000_6008);
        ret_check(32'h0000_3080, 1'b1, 32'h0000_6008);
        ret_check(32'h0000_3080, 1'b1, 32'h0000_5004);
        ret_check(32'h0000_3080, 1'b0, 32'h0000_3088);
        // Outstanding guess makes the next pop speculative
        push_call(32'h0000_700c);
        execute(32'h0000_30c8, kind_guess, 1'b1, 32'h0000_3400, 1'b0);
        check_pc(32'h0000_30c8, 1'b1);
        ret_check(32'h0000_3080, 1'b1, 32'h0000_700c);
        ret_check(32'h0000_3080, 1'b0, 32'h0000_3088);
        execute(32'h0000_30c8, kind_guess, 1'b0, 32'h0000_3400, 1'b1);
        ret_check(32'h0000_3080, 1'b0, 32'h0000_700c);
    endtask

    initial begin
        #100_000;
        $display("simulation ran past its time limit");
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        seed       = 32'hda5b_230b;
        tgt_valid  = '0;
        hist_valid = '0;
        rstn       = 1'b0;
        fetch_en   = 1'b0;
        pc_now     = 32'h0;
        call_push  = 1'b0;
        call_addr  = 32'h0;
        ex_vld     = 1'b0;
        ex_wrong   = 1'b0;
        ex_pc      = 32'h0;
        ex_taken   = 1'b0;
        ex_kind    = 2'b00;
        ex_target  = 32'h0;
        repeat (10) @(posedge clk);
        #2;
        rstn = 1'b1;
        wait_reset_done();
        idle_predictions();
        slot_priority();
        static_direction();
        counter_training();
        return_addresses();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- fetch_predictor.f
logic/predict_pkg.sv
logic/lut_memory.sv
logic/target_buffer.sv
logic/history_table.sv
logic/return_stack.sv
logic/predict_unit.sv
logic/fetch_predictor.sv
verif/tb_clock.sv
verif/fetch_predictor_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module fetch_predictor_tb \
    -f fetch_predictor.f -o fetch_predictor_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/fetch_predictor_sim > sim.log 2>&1
grep -qF '*** TEST PASSED ***' sim.log && echo "simulation passed" \
    || { cat sim.log; echo "simulation failed"; exit 1; }
